//--- hexCommandMonitor.sv
`include "ramMonitor_settings.svh"

module hexCommandMonitor (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   enable,
    input  logic                   received,
    input  logic [7:0]             rxByte,
    output logic                   transmit,
    output logic [7:0]             txByte,
    input  logic                   transmitting,
    output logic                   cmdTrigger,
    output ramMonitorPkg::memAddrT cmdAddr,
    output logic                   cmdWrite,
    output ramMonitorPkg::memDataT cmdWriteData,
    input  logic                   cmdReady,
    input  ramMonitorPkg::memDataT cmdReadData,
    input  logic                   cmdReadDataValid
);
    import ramMonitorPkg::*;

    localparam int AddrDigits = `RAM_ADDR_WIDTH / 4;
    localparam int DataDigits = `RAM_DATA_WIDTH / 4;
    localparam int CountWidth = $clog2(DataDigits + 1);
    localparam int BufWidth = 8 * DataDigits;

    monStageT              stage;
    logic [CountWidth-1:0] inCount;     // Characters still to load
    logic [CountWidth-1:0] outCount;    // Characters waiting in outBuf
    logic [CountWidth-1:0] shiftedCount;
    logic                  suppress;
    logic                  readValid;
    memDataT               readData;
    logic [BufWidth-1:0]   inBuf;       // Newest character in the low byte
    logic [BufWidth-1:0]   outBuf;      // Oldest character in the low byte
    logic [BufWidth-1:0]   shiftedBuf;
    logic [BufWidth-1:0]   hexWord;
    memAddrT               digitAddr;
    memDataT               digitData;
    logic                  popNow;
    logic                  loadByte;
    logic                  echoPush;
    logic                  step;
    logic                  cmdIsWrite;

    function automatic logic [3:0] nibbleFromHex(input logic [7:0] c);
        return (c >= 8'h61) ? 4'(c - 8'h57) : 4'(c - 8'h30);
    endfunction

    function automatic logic [7:0] hexFromNibble(input logic [3:0] n);
        return (n < 4'd10) ? 8'h30 + 8'(n) : 8'h57 + 8'(n);   // Lowercase a-f
    endfunction

    always_comb begin
        for (int i = 0; i < AddrDigits; i++)
            digitAddr[4*i +: 4] = nibbleFromHex(inBuf[8*i +: 8]);
        for (int i = 0; i < DataDigits; i++) begin
            digitData[4*i +: 4] = nibbleFromHex(inBuf[8*i +: 8]);
            hexWord[8*i +: 8] = hexFromNibble(readData[4*(DataDigits-1-i) +: 4]);
        end
    end

    // Hand the oldest character to the UART when it is free
    assign popNow = !transmit && !transmitting && outCount != '0;
    assign shiftedBuf = popNow ? outBuf >> 8 : outBuf;
    assign shiftedCount = popNow ? outCount - 1'b1 : outCount;

    assign loadByte = enable && received && inCount != '0;
    assign echoPush = loadByte && !suppress;
    assign step = enable && inCount == '0 && outCount == '0;
    assign cmdIsWrite = inBuf[7:0] == "w";

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stage <= waitCmd;
            inCount <= '0;
            outCount <= '0;
            suppress <= 1'b0;
            transmit <= 1'b0;
            cmdTrigger <= 1'b0;
            cmdWrite <= 1'b0;
            readValid <= 1'b0;
        end else begin
            transmit <= popNow;
            if (cmdTrigger && cmdReady)
                cmdTrigger <= 1'b0;             // Accepted
            if (cmdReadDataValid)
                readValid <= 1'b1;
            outCount <= shiftedCount + CountWidth'(echoPush);
            if (loadByte)
                inCount <= inCount - 1'b1;
            if (step) begin
                suppress <= 1'b0;
                case (stage)
                    waitCmd: begin
                        inCount <= CountWidth'(1);
                        suppress <= 1'b1;       // Command byte is echoed as w or r
                        stage <= loadCmd;
                    end
                    loadCmd: begin
                        cmdWrite <= cmdIsWrite;
                        outCount <= CountWidth'(1);
                        inCount <= CountWidth'(AddrDigits);
                        stage <= loadAddr;
                    end
                    loadAddr: begin
                        outCount <= CountWidth'(1);
                        if (cmdWrite)
                            inCount <= CountWidth'(DataDigits);
                        stage <= issue;
                    end
                    issue: begin
                        cmdTrigger <= 1'b1;
                        readValid <= 1'b0;
                        stage <= waitMem;
                    end
                    waitMem: begin
                        if (!cmdTrigger && (cmdWrite || readValid))
                            stage <= printData;
                    end
                    printData: begin
                        if (!cmdWrite)
                            outCount <= CountWidth'(DataDigits);
                        stage <= newline;
                    end
                    default: begin
                        outCount <= CountWidth'(2);
                        stage <= waitCmd;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (popNow)
            txByte <= outBuf[7:0];
        if (loadByte)
            inBuf <= {inBuf[BufWidth-9:0], rxByte};
        if (cmdReadDataValid)
            readData <= cmdReadData;
        if (step) begin
            case (stage)
                loadCmd:   outBuf <= BufWidth'(cmdIsWrite ? "w" : "r");
                loadAddr: begin
                    outBuf <= BufWidth'("=");
                    cmdAddr <= digitAddr;
                end
                issue:     if (cmdWrite) cmdWriteData <= digitData;
                printData: if (!cmdWrite) outBuf <= hexWord;
                newline:   outBuf <= BufWidth'({8'h0A, 8'h0D});   // CR goes first
                default:   outBuf <= outBuf;
            endcase
        end else begin
            outBuf <= shiftedBuf;
            if (echoPush)
                outBuf[8*shiftedCount +: 8] <= rxByte;
        end
    end

endmodule

//--- memArbiter.sv
module memArbiter #(
    parameter type dataT = logic [15:0]
) (
    input  logic                   clk,
    input  logic                   rstN,
    // Port A, higher priority
    input  logic                   aTrigger,
    input  ramMonitorPkg::memAddrT aAddr,
    input  logic                   aWrite,
    input  dataT                   aWriteData,
    output logic                   aReady,
    // Port B
    input  logic                   bTrigger,
    input  ramMonitorPkg::memAddrT bAddr,
    input  logic                   bWrite,
    input  dataT                   bWriteData,
    output logic                   bReady,
    output dataT                   bReadData,
    output logic                   bReadDataValid,
    // Controller side
    output logic                   cmdTrigger,
    output ramMonitorPkg::memAddrT cmdAddr,
    output logic                   cmdWrite,
    output dataT                   cmdWriteData,
    input  logic                   cmdReady,
    input  dataT                   cmdReadData,
    input  logic                   cmdReadDataValid
);
    logic grantA;
    logic readOwnerB;   // Owner of the read in flight

    assign grantA = aTrigger;

    assign cmdTrigger = aTrigger || bTrigger;
    assign cmdAddr = grantA ? aAddr : bAddr;
    assign cmdWrite = grantA ? aWrite : bWrite;
    assign cmdWriteData = grantA ? aWriteData : bWriteData;

    assign aReady = grantA && cmdReady;
    assign bReady = !grantA && cmdReady;

    assign bReadData = cmdReadData;
    assign bReadDataValid = cmdReadDataValid && readOwnerB;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            readOwnerB <= 1'b0;
        else if (cmdTrigger && cmdReady && !cmdWrite)
            readOwnerB <= !grantA;
    end

endmodule

//--- memController.sv
`include "ramMonitor_settings.svh"

module memController (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   cmdTrigger,
    input  ramMonitorPkg::memAddrT cmdAddr,
    input  logic                   cmdWrite,
    input  ramMonitorPkg::memDataT cmdWriteData,
    output logic                   cmdReady,
    output ramMonitorPkg::memDataT cmdReadData,
    output logic                   cmdReadDataValid
);
    import ramMonitorPkg::*;

    localparam int Depth = 1 << `RAM_ADDR_WIDTH;
    localparam int Latency = `READ_LATENCY;
    localparam int Interval = `REFRESH_INTERVAL;
    localparam int RefreshLen = `REFRESH_CYCLES;
    localparam int TimerWidth = $clog2(Interval);
    localparam int LeftWidth = $clog2(RefreshLen + 1);

    memDataT               mem [Depth];
    logic [TimerWidth-1:0] refreshTimer;    // Counts down to the next refresh
    logic [LeftWidth-1:0]  refreshLeft;     // Refresh clocks remaining
    logic [Latency-1:0]    readPipe;
    logic                  refreshing;
    logic                  readBusy;
    logic                  accept;

    assign refreshing = refreshLeft != '0;
    assign readBusy = |readPipe;
    assign cmdReady = !refreshing && !readBusy;
    assign accept = cmdTrigger && cmdReady;
    assign cmdReadDataValid = readPipe[Latency-1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            refreshTimer <= TimerWidth'(Interval - 1);
            refreshLeft <= '0;
            readPipe <= '0;
        end else begin
            readPipe <= (readPipe << 1) | Latency'(accept && !cmdWrite);
            if (refreshTimer == '0) begin
                refreshTimer <= TimerWidth'(Interval - 1);
                refreshLeft <= LeftWidth'(RefreshLen);  // Refresh starts
            end else begin
                refreshTimer <= refreshTimer - 1'b1;
                if (refreshing)
                    refreshLeft <= refreshLeft - 1'b1;
            end
        end
    end

    // Read word is captured on acceptance and held until valid
    always_ff @(posedge clk) begin
        if (accept) begin
            if (cmdWrite)
                mem[cmdAddr] <= cmdWriteData;
            else
                cmdReadData <= mem[cmdAddr];
        end
    end

endmodule

//--- memFillEngine.sv
`include "ramMonitor_settings.svh"

module memFillEngine (
    input  logic                   clk,
    input  logic                   rstN,
    output logic                   cmdTrigger,
    output ramMonitorPkg::memAddrT cmdAddr,
    output ramMonitorPkg::memDataT cmdWriteData,
    input  logic                   cmdReady,
    output logic                   fillDone
);
    import ramMonitorPkg::*;

    localparam memAddrT LastAddr = '1;

    assign cmdWriteData = memDataT'(`RAM_FILL_VALUE);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cmdTrigger <= 1'b0;
            cmdAddr <= '0;
            fillDone <= 1'b0;
        end else if (!fillDone) begin
            cmdTrigger <= 1'b1;
            if (cmdTrigger && cmdReady) begin
                if (cmdAddr == LastAddr) begin
                    cmdTrigger <= 1'b0;     // Whole array written
                    fillDone <= 1'b1;
                end else begin
                    cmdAddr <= cmdAddr + 1'b1;
                end
            end
        end
    end

endmodule

//--- ramMonitor.f
+incdir+.
ramMonitorPkg.sv
uartPort.sv
hexCommandMonitor.sv
memFillEngine.sv
memArbiter.sv
memController.sv
ramMonitorTop.sv
tbClock.sv
ramMonitorTb.sv

//--- ramMonitorPkg.sv
`include "ramMonitor_settings.svh"

package ramMonitorPkg;

    typedef logic [`RAM_ADDR_WIDTH-1:0] memAddrT;   // Word address
    typedef logic [`RAM_DATA_WIDTH-1:0] memDataT;   // One memory word

    // Command sequence of the monitor, one stage per step
    typedef enum logic [2:0] {
        waitCmd,    // Arm input for the command byte
        loadCmd,    // Decode command, echo w or r
        loadAddr,   // Latch address, echo =
        issue,      // Raise the memory trigger
        waitMem,    // Wait for acceptance and read data
        printData,  // Queue the read word as hex
        newline     // Queue CR LF
    } monStageT;

endpackage

//--- ramMonitorTb.sv
`include "ramMonitor_settings.svh"

module ramMonitorTb;
    import ramMonitorPkg::*;

    localparam int ClksPerBit = `UART_CLKS_PER_BIT;
    localparam int Depth = 1 << `RAM_ADDR_WIDTH;
    localparam int AddrDigits = `RAM_ADDR_WIDTH / 4;
    localparam int DataDigits = `RAM_DATA_WIDTH / 4;
    localparam int ResetCycles = 10;
    localparam int FillCycles =
        Depth * `REFRESH_INTERVAL / (`REFRESH_INTERVAL - `REFRESH_CYCLES);
    localparam int NumCommands = 20 + 1 + 80 + 16 + 32;
    localparam int BytesPerCmd = 19;    // Write command, bytes in and out
    localparam int TimeoutCycles =
        2 * (NumCommands * BytesPerCmd * 10 * ClksPerBit + FillCycles + ResetCycles);
    localparam int ByteWaitCycles = 40 * ClksPerBit;

    logic         clk;
    logic         rstN;
    logic         rxSerial;
    logic         txSerial;
    logic         ready;
    logic [31:0]  lfsrState;
    memDataT      shadow [Depth];       // Expected memory contents
    memAddrT      written [$];
    byte unsigned rxQueue [$];          // Bytes decoded from txSerial
    byte unsigned expectQueue [$];
    int           errorCount;
    int           checkCount;

    tbClock tbClock_inst (.clk);

    ramMonitorTop ramMonitorTop_inst (.clk, .rstN, .rxSerial, .txSerial, .ready);

    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return state[0] ? (state >> 1) ^ 32'hA300_0000 : state >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic takeBits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = lfsrStep(lfsrState);
        end
    endtask

    function automatic byte unsigned hexChar(input logic [3:0] nibble);
        return (nibble < 4'd10) ? "0" + 8'(nibble) : "a" + 8'(nibble) - 8'd10;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic sendByte(input byte unsigned value, input bit zeroGap);
        logic [9:0]  frame;
        logic [31:0] gap;
        frame = {1'b1, value, 1'b0};    // Stop, data LSB first, start
        for (int i = 0; i < 10; i++) begin
            rxSerial <= frame[i];
            repeat (ClksPerBit) @(posedge clk);
        end
        if (!zeroGap) begin
            takeBits(2, gap);
            repeat (gap * ClksPerBit) @(posedge clk);
        end
    endtask

    task automatic receiveResponse();
        int waited;
        foreach (expectQueue[i]) begin
            waited = 0;
            while (rxQueue.size() == 0 && waited < ByteWaitCycles) begin
                @(posedge clk);
                waited++;
            end
            if (rxQueue.size() == 0) begin
                errorCount++;
                $display("Missing byte %0d of the response at %0t, txSerial stayed idle",
                         i, $time);
                return;
            end
            checkValue($sformatf("txSerial byte %0d", i), expectQueue[i], rxQueue.pop_front());
        end
    endtask

    // Send one command and check the full echo and result
    task automatic runCommand(input byte unsigned cmd, input memAddrT addr,
                              input memDataT data, input bit zeroGap);
        bit isWrite;
        isWrite = cmd == "w";
        expectQueue.delete();
        sendByte(cmd, zeroGap);
        expectQueue.push_back(isWrite ? "w" : "r");
        for (int i = AddrDigits - 1; i >= 0; i--) begin
            sendByte(hexChar(addr[4*i +: 4]), zeroGap);
            expectQueue.push_back(hexChar(addr[4*i +: 4]));
        end
        expectQueue.push_back("=");
        if (isWrite) begin
            for (int i = DataDigits - 1; i >= 0; i--) begin
                sendByte(hexChar(data[4*i +: 4]), zeroGap);
                expectQueue.push_back(hexChar(data[4*i +: 4]));
            end
            shadow[addr] = data;
        end else begin
            for (int i = DataDigits - 1; i >= 0; i--)
                expectQueue.push_back(hexChar(shadow[addr][4*i +: 4]));
        end
        expectQueue.push_back(8'h0D);
        expectQueue.push_back(8'h0A);
        receiveResponse();
    endtask

    task automatic reportTest(input string name, input int commands, input int startErrors);
        $display("%s: %0d commands, %0d errors", name, commands, errorCount - startErrors);
    endtask

    initial begin : txDecoder
        logic [7:0] value;
        forever begin
            @(negedge clk);
            if (rstN && txSerial === 1'b0) begin
                repeat (ClksPerBit / 2) @(negedge clk);    // Middle of start bit
                for (int i = 0; i < 8; i++) begin
                    repeat (ClksPerBit) @(negedge clk);
                    value[i] = txSerial;
                end
                repeat (ClksPerBit) @(negedge clk);
                if (txSerial !== 1'b1) begin
                    errorCount++;
                    $display("Stop bit missing on txSerial at %0t", $time);
                end
                rxQueue.push_back(value);
            end
        end
    end

    initial begin : watchdog
        repeat (TimeoutCycles) @(posedge clk);
        $display("Timeout: the run did not end within %0d clock cycles", TimeoutCycles);
        $display("test failed");
        $finish;
    end

    initial begin : mainSequence
        logic [31:0]  bits;
        logic [31:0]  data;
        memAddrT      addr;
        byte unsigned cmd;
        logic         idleLevel;
        int           startErrors;
        int           waited;

        lfsrState = 32'h9962_3553;
        errorCount = 0;
        checkCount = 0;
        rstN = 1'b0;
        rxSerial = 1'b1;
        foreach (shadow[i])
            shadow[i] = memDataT'(`RAM_FILL_VALUE);
        repeat (ResetCycles) @(posedge clk);
        rstN <= 1'b1;

        // Ready rises once the fill is over, no serial output meanwhile
        startErrors = errorCount;
        idleLevel = 1'b1;
        waited = 0;
        @(negedge clk);
        checkValue("ready", 0, ready);
        while (ready !== 1'b1 && waited < 2 * FillCycles) begin
            idleLevel = idleLevel & txSerial;
            @(negedge clk);
            waited++;
        end
        if (ready !== 1'b1) begin
            errorCount++;
            $display("ready did not rise within %0d cycles after reset", 2 * FillCycles);
        end
        repeat (20 * ClksPerBit) begin
            idleLevel = idleLevel & txSerial;
            @(negedge clk);
        end
        checkValue("txSerial", 1, idleLevel);
        checkValue("decoded byte count", 0, rxQueue.size());
        @(posedge clk);
        reportTest("Ready and idle line", 0, startErrors);

        startErrors = errorCount;
        for (int n = 0; n < 20; n++) begin
            takeBits(`RAM_ADDR_WIDTH, bits);
            runCommand("r", memAddrT'(bits), '0, 1'b0);
        end
        reportTest("Fill readback", 20, startErrors);

        startErrors = errorCount;
        takeBits(`RAM_ADDR_WIDTH, bits);
        takeBits(`RAM_DATA_WIDTH, data);
        runCommand("w", memAddrT'(bits), memDataT'(data), 1'b0);
        written.push_back(memAddrT'(bits));
        reportTest("Write echo", 1, startErrors);

        startErrors = errorCount;
        for (int n = 0; n < 40; n++) begin
            takeBits(`RAM_ADDR_WIDTH, bits);
            takeBits(`RAM_DATA_WIDTH, data);
            runCommand("w", memAddrT'(bits), memDataT'(data), 1'b0);
            written.push_back(memAddrT'(bits));
        end
        for (int n = 0; n < 40; n++) begin
            takeBits(1, bits);
            if (bits[0]) begin
                takeBits(6, bits);
                addr = written[bits % written.size()];
            end else begin
                takeBits(`RAM_ADDR_WIDTH, bits);
                addr = memAddrT'(bits);
            end
            runCommand("r", addr, '0, 1'b0);
        end
        reportTest("Read after write", 80, startErrors);

        // Any command byte other than w reads
        startErrors = errorCount;
        for (int n = 0; n < 8; n++) begin
            takeBits(5, bits);
            cmd = 8'("a" + bits % 26);
            if (cmd == "w")
                cmd = "x";
            takeBits(6, bits);
            addr = written[bits % written.size()];
            runCommand(cmd, addr, '0, 1'b0);
            runCommand("r", addr, '0, 1'b0);
        end
        reportTest("Other command bytes", 16, startErrors);

        startErrors = errorCount;
        for (int n = 0; n < 32; n++) begin
            takeBits(4, bits);
            addr = memAddrT'(12'h0F0 + bits);   // Small window so reads hit writes
            takeBits(`RAM_DATA_WIDTH, data);
            takeBits(1, bits);
            runCommand(bits[0] ? "w" : "r", addr, memDataT'(data), 1'b1);
        end
        reportTest("Back to back", 32, startErrors);

        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

//--- ramMonitorTop.sv
module ramMonitorTop (
    input  logic clk,
    input  logic rstN,
    input  logic rxSerial,
    output logic txSerial,
    output logic ready
);
    import ramMonitorPkg::*;

    logic       transmit;
    logic [7:0] txByte;
    logic       received;
    logic [7:0] rxByte;
    logic       transmitting;

    logic    fillTrigger;
    memAddrT fillAddr;
    memDataT fillWriteData;
    logic    fillReady;

    logic    monTrigger;
    memAddrT monAddr;
    logic    monWrite;
    memDataT monWriteData;
    logic    monReady;
    memDataT monReadData;
    logic    monReadDataValid;

    logic    cmdTrigger;
    memAddrT cmdAddr;
    logic    cmdWrite;
    memDataT cmdWriteData;
    logic    cmdReady;
    memDataT cmdReadData;
    logic    cmdReadDataValid;

    uartPort uartPort_inst (
        .clk, .rstN, .rxSerial, .txSerial,
        .transmit, .txByte, .received, .rxByte, .transmitting
    );

    // Monitor waits for the fill to finish
    hexCommandMonitor hexCommandMonitor_inst (
        .clk, .rstN, .enable(ready),
        .received, .rxByte, .transmit, .txByte, .transmitting,
        .cmdTrigger(monTrigger), .cmdAddr(monAddr), .cmdWrite(monWrite),
        .cmdWriteData(monWriteData), .cmdReady(monReady),
        .cmdReadData(monReadData), .cmdReadDataValid(monReadDataValid)
    );

    memFillEngine memFillEngine_inst (
        .clk, .rstN,
        .cmdTrigger(fillTrigger), .cmdAddr(fillAddr), .cmdWriteData(fillWriteData),
        .cmdReady(fillReady), .fillDone(ready)
    );

    memArbiter #(.dataT(memDataT)) memArbiter_inst (
        .clk, .rstN,
        .aTrigger(fillTrigger), .aAddr(fillAddr), .aWrite(1'b1),   // Fill only writes
        .aWriteData(fillWriteData), .aReady(fillReady),
        .bTrigger(monTrigger), .bAddr(monAddr), .bWrite(monWrite),
        .bWriteData(monWriteData), .bReady(monReady),
        .bReadData(monReadData), .bReadDataValid(monReadDataValid),
        .cmdTrigger, .cmdAddr, .cmdWrite, .cmdWriteData,
        .cmdReady, .cmdReadData, .cmdReadDataValid
    );

    memController memController_inst (
        .clk, .rstN, .cmdTrigger, .cmdAddr, .cmdWrite, .cmdWriteData,
        .cmdReady, .cmdReadData, .cmdReadDataValid
    );

endmodule

//--- ramMonitor_settings.svh
`ifndef RAM_MONITOR_SETTINGS_SVH
`define RAM_MONITOR_SETTINGS_SVH

// Memory geometry, three address digits and four data digits
`define RAM_ADDR_WIDTH 12
`define RAM_DATA_WIDTH 16
`define RAM_FILL_VALUE 16'hFFFF

`define UART_CLKS_PER_BIT 8     // Short bit time keeps simulation fast

`define REFRESH_INTERVAL 64     // Clocks between refresh starts
`define REFRESH_CYCLES 6        // Clocks the controller is blocked per refresh
`define READ_LATENCY 2          // Acceptance to read data valid

`endif

//--- run.sh
#!/usr/bin/env bash
# Build and run the ramMonitor simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f ramMonitor.f \
    --top-module ramMonitorTb -o ramMonitorSim

output=$(./obj_dir/ramMonitorSim)
echo "$output"

if grep -qx "test passed" <<< "$output"; then
    exit 0
fi
exit 1

//--- tbClock.sv
module tbClock (
    output logic clk
);
    localparam int HalfPeriod = 2;  // Full period is 4 time units

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

endmodule

//--- uartPort.sv
`include "ramMonitor_settings.svh"

module uartPort (
    input  logic       clk,
    input  logic       rstN,
    input  logic       rxSerial,
    output logic       txSerial,
    input  logic       transmit,
    input  logic [7:0] txByte,
    output logic       received,
    output logic [7:0] rxByte,
    output logic       transmitting
);
    localparam int ClksPerBit = `UART_CLKS_PER_BIT;
    localparam int CntWidth = $clog2(ClksPerBit);

    logic [1:0]          rxSync;
    logic                rxIn;
    logic                rxBusy;
    logic [CntWidth-1:0] rxCnt;
    logic [3:0]          rxBit;     // 0 start, 1..8 data, 9 stop
    logic [7:0]          rxShift;
    logic                rxSample;

    logic [CntWidth-1:0] txCnt;
    logic [3:0]          txBit;
    logic [9:0]          txShift;   // Stop, data, start

    assign rxIn = rxSync[1];
    assign rxSample = rxBusy && rxCnt == '0;   // Middle of the current bit

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rxSync <= 2'b11;
            rxBusy <= 1'b0;
            rxCnt <= '0;
            rxBit <= '0;
            received <= 1'b0;
        end else begin
            rxSync <= {rxSync[0], rxSerial};
            received <= 1'b0;
            if (!rxBusy) begin
                if (!rxIn) begin
                    // Falling edge, aim at the middle of the start bit
                    rxBusy <= 1'b1;
                    rxCnt <= CntWidth'(ClksPerBit / 2 - 1);
                    rxBit <= '0;
                end
            end else if (rxCnt != '0) begin
                rxCnt <= rxCnt - 1'b1;
            end else begin
                rxCnt <= CntWidth'(ClksPerBit - 1);
                rxBit <= rxBit + 1'b1;
                if (rxBit == 4'd0 && rxIn) begin
                    rxBusy <= 1'b0;     // Glitch, no start bit
                end else if (rxBit == 4'd9) begin
                    rxBusy <= 1'b0;
                    received <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rxSample && rxBit >= 4'd1 && rxBit <= 4'd8)
            rxShift <= {rxIn, rxShift[7:1]};   // LSB arrives first
        if (rxSample && rxBit == 4'd9)
            rxByte <= rxShift;
    end

    // Transmitter
    assign txSerial = transmitting ? txShift[0] : 1'b1;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            transmitting <= 1'b0;
            txCnt <= '0;
            txBit <= '0;
        end else if (!transmitting) begin
            if (transmit) begin
                transmitting <= 1'b1;
                txCnt <= CntWidth'(ClksPerBit - 1);
                txBit <= '0;
            end
        end else if (txCnt != '0) begin
            txCnt <= txCnt - 1'b1;
        end else begin
            txCnt <= CntWidth'(ClksPerBit - 1);
            if (txBit == 4'd9)
                transmitting <= 1'b0;           // End of stop bit
            else
                txBit <= txBit + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (transmit && !transmitting)
            txShift <= {1'b1, txByte, 1'b0};
        else if (transmitting && txCnt == '0)
            txShift <= {1'b1, txShift[9:1]};
    end

endmodule
